/* hw/quant_cfg_pkg.sv */
`default_nettype none

package quant_cfg_pkg;

    //////////////////////////////////////////////////////////////
    // array geometry
    //////////////////////////////////////////////////////////////

    // columns of the systolic array feeding this tail
    localparam int column_num = 4;
    // each column hands over two pixels per channel
    localparam int pix_per_column = 2;
    // pixels per channel, 8 with the reduced geometry
    localparam int lanes_per_chan = column_num * pix_per_column;
    // two weight channels in mode 1x8
    localparam int chan_num = 2;
    // total multiplier lanes
    localparam int lane_num = chan_num * lanes_per_chan;

    //////////////////////////////////////////////////////////////
    // pixel and row widths
    //////////////////////////////////////////////////////////////

    // accumulator pixel in mode 8x8, 16 bit plus headroom
    localparam int pix88_width = 24;
    // accumulator pixel in mode 1x8
    localparam int pix18_width = 16;
    // full input row, sized by the 1x8 packing
    localparam int row_width = lane_num * pix18_width;
    // low part of the row that carries the 8x8 pixels
    localparam int row88_width = lanes_per_chan * pix88_width;

    //////////////////////////////////////////////////////////////
    // scale set and multiplier widths
    //////////////////////////////////////////////////////////////

    localparam int tail_width = 16;
    localparam int rank_width = 8;

    localparam int mult_a_width = 24;
    localparam int mult_b_width = 16;
    localparam int mult_p_width = mult_a_width + mult_b_width;
    // meaningful product bits in mode 1x8
    localparam int prod18_width = pix18_width + tail_width;

    // quantized output
    localparam int qpix_width = 8;
    localparam int qrow_width = lane_num * qpix_width;

endpackage

`default_nettype wire

/* hw/quant_types_pkg.sv */
`default_nettype none

package quant_types_pkg;

    import quant_cfg_pkg::*;

    //////////////////////////////////////////////////////////////
    // precision mode, travels with each row
    //////////////////////////////////////////////////////////////

    typedef enum logic {
        mode_8x8 = 1'b0,
        mode_1x8 = 1'b1
    } quant_mode_e;

    //////////////////////////////////////////////////////////////
    // per channel scale set
    //////////////////////////////////////////////////////////////

    // index 0 is channel 0, the low field of each array
    typedef struct packed {
        logic [chan_num-1:0][tail_width-1:0] tail;
        logic [chan_num-1:0][rank_width-1:0] rank;
    } scale_set_t;

    //////////////////////////////////////////////////////////////
    // stage to stage payloads
    //////////////////////////////////////////////////////////////

    // operand stage -> multiplier array
    typedef struct packed {
        logic [lane_num-1:0][mult_a_width-1:0] a;
        logic [lane_num-1:0][mult_b_width-1:0] b;
        quant_mode_e                           mode;
        logic [chan_num-1:0][rank_width-1:0]   rank;
    } mult_operands_t;

    // multiplier array -> output stage
    // mode and rank ride along so each row keeps its own controls
    typedef struct packed {
        logic [lane_num-1:0][mult_p_width-1:0] p;
        quant_mode_e                           mode;
        logic [chan_num-1:0][rank_width-1:0]   rank;
    } product_row_t;

    // final quantized row, lane 0 in the low byte
    typedef struct packed {
        logic [lane_num-1:0][qpix_width-1:0] pix;
    } quant_row_t;

endpackage

`default_nettype wire

/* hw/scale_operand_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module scale_operand_stage
    import quant_cfg_pkg::*;
    import quant_types_pkg::*;
(
    input  wire            clk,
    input  wire            e_tail_reset,
    // row of bias-added pixels, cycle t
    input  wire [row_width-1:0] add_bias_row,
    input  wire quant_mode_e    mode,
    // scale set for this row, presented one cycle early
    input  wire scale_set_t     scale_set,
    output mult_operands_t      operands
);

    //////////////////////////////////////////////////////////////
    // scale set alignment
    //////////////////////////////////////////////////////////////

    // scale set from cycle t-1, lines up with the row in cycle t
    scale_set_t scale_q;

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            scale_q <= '0;
        end else begin
            scale_q <= scale_set;
        end
    end

    //////////////////////////////////////////////////////////////
    // row views per mode
    //////////////////////////////////////////////////////////////

    // mode 8x8 uses only the low part of the row
    logic [lanes_per_chan-1:0][pix88_width-1:0] row_88;
    // mode 1x8 packs both channels, channel 0 in the low half
    logic [lane_num-1:0][pix18_width-1:0]       row_18;

    assign row_88 = add_bias_row[row88_width-1:0];
    assign row_18 = add_bias_row;

    //////////////////////////////////////////////////////////////
    // operand build
    //////////////////////////////////////////////////////////////

    always_comb begin
        // lower lane half, channel 0 in both modes
        for (int i = 0; i < lanes_per_chan; i++) begin
            if (mode == mode_8x8) begin
                operands.a[i] = row_88[i];
            end else begin
                // 16 bit pixel zero extended to the A width
                operands.a[i] = {{(mult_a_width - pix18_width){1'b0}}, row_18[i]};
            end
            operands.b[i] = scale_q.tail[0];
        end

        // upper lane half, channel 1 only in mode 1x8
        for (int i = lanes_per_chan; i < lane_num; i++) begin
            if (mode == mode_1x8) begin
                operands.a[i] = {{(mult_a_width - pix18_width){1'b0}}, row_18[i]};
                operands.b[i] = scale_q.tail[1];
            end else begin
                // idle half in mode 8x8, A forced to zero
                operands.a[i] = '0;
                // B still tail 0 so every lane sees the same scale
                operands.b[i] = scale_q.tail[0];
            end
        end

        // controls follow the row into the multiplier
        operands.mode = mode;
        // rank delayed once here, once more in the multiplier array
        operands.rank = scale_q.rank;
    end

endmodule

`default_nettype wire

/* hw/scale_mult_array.sv */
`timescale 1ns/100ps
`default_nettype none

module scale_mult_array
    import quant_cfg_pkg::*;
    import quant_types_pkg::*;
(
    input  wire            clk,
    input  wire            e_tail_reset,
    // operands from the operand stage, cycle t
    input  wire mult_operands_t operands,
    // registered products, valid in cycle t+1
    output product_row_t        products
);

    //////////////////////////////////////////////////////////////
    // lane multipliers
    //////////////////////////////////////////////////////////////

    // unsigned 24 x 16, full 40 bit result per lane
    logic [lane_num-1:0][mult_p_width-1:0] lane_prod;

    for (genvar i = 0; i < lane_num; i++) begin : g_lane
        // both operands widen to the product width before the multiply
        assign lane_prod[i] = mult_p_width'(operands.a[i]) * mult_p_width'(operands.b[i]);
    end

    //////////////////////////////////////////////////////////////
    // product register
    //////////////////////////////////////////////////////////////

    // mode and rank are captured with their own products
    // so rows of different modes can be in flight together
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            products <= '0;
        end else begin
            products.p    <= lane_prod;
            products.mode <= operands.mode;
            // second rank delay, lines up with the products
            products.rank <= operands.rank;
        end
    end

endmodule

`default_nettype wire

/* hw/quant_output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module quant_output_stage
    import quant_cfg_pkg::*;
    import quant_types_pkg::*;
(
    input  wire            clk,
    input  wire            e_tail_reset,
    // load strobe for the output register, cycle t+1
    input  wire            quantify_en,
    // clear pulse, wins over quantify_en
    input  wire            quantify_reset,
    input  wire product_row_t products,
    // quantized row, visible from cycle t+2
    output quant_row_t        quantified_row
);

    //////////////////////////////////////////////////////////////
    // per lane rank shift and fit test
    //////////////////////////////////////////////////////////////

    // product slice selected by mode
    logic [lane_num-1:0][mult_p_width-1:0] lane_slice;
    // slice after the channel rank shift
    logic [lane_num-1:0][mult_p_width-1:0] lane_shift;
    // shifted value fits into an 8 bit pixel
    logic [lane_num-1:0]                   lane_fit;
    // upper half in mode 8x8 carries no channel
    logic [lane_num-1:0]                   lane_idle;
    // next value for the output register, lane 0 in the low byte
    logic [qrow_width-1:0]                 next_row;

    for (genvar i = 0; i < lane_num; i++) begin : g_lane
        // mode 8x8 keeps all 40 bits, mode 1x8 only the low 32
        assign lane_slice[i] = (products.mode == mode_8x8) ? products.p[i] :
            {{(mult_p_width - prod18_width){1'b0}}, products.p[i][prod18_width-1:0]};

        // lanes 0-7 use rank 0, lanes 8-15 use rank 1
        assign lane_shift[i] = lane_slice[i] >> products.rank[i / lanes_per_chan];

        // anything above 255 does not fit
        assign lane_fit[i] = (lane_shift[i][mult_p_width-1:qpix_width] == '0);

        assign lane_idle[i] = (products.mode == mode_8x8) && (i >= lanes_per_chan);

        // overflow and idle lanes both give zero
        assign next_row[i*qpix_width +: qpix_width] =
            (lane_fit[i] && !lane_idle[i]) ? lane_shift[i][qpix_width-1:0] : '0;
    end

    //////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////

    // holds its value until the next enabled load
    always_ff @(posedge clk) begin
        if (e_tail_reset || quantify_reset) begin
            quantified_row <= '0;
        end else if (quantify_en) begin
            quantified_row <= next_row;
        end
    end

endmodule

`default_nettype wire

/* hw/requant_top.sv */
`timescale 1ns/100ps
`default_nettype none

module requant_top
    import quant_cfg_pkg::*;
    import quant_types_pkg::*;
(
    input  wire                 clk,
    input  wire                 e_tail_reset,
    // cycle t inputs
    input  wire [row_width-1:0] add_bias_row,
    input  wire quant_mode_e    mode,
    // cycle t-1 input
    input  wire scale_set_t     scale_set,
    // cycle t+1 controls for the output register
    input  wire                 quantify_en,
    input  wire                 quantify_reset,
    // result of row t, from cycle t+2
    output quant_row_t          quantified_row
);

    //////////////////////////////////////////////////////////////
    // stage chain
    //////////////////////////////////////////////////////////////

    // combinational, cycle t
    mult_operands_t operands;
    // registered, cycle t+1
    product_row_t   products;

    scale_operand_stage u_operand (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .add_bias_row (add_bias_row),
        .mode         (mode),
        .scale_set    (scale_set),
        .operands     (operands)
    );

    scale_mult_array u_mult (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .operands     (operands),
        .products     (products)
    );

    // shift, fit test and output register
    quant_output_stage u_output (
        .clk            (clk),
        .e_tail_reset   (e_tail_reset),
        .quantify_en    (quantify_en),
        .quantify_reset (quantify_reset),
        .products       (products),
        .quantified_row (quantified_row)
    );

endmodule

`default_nettype wire

/* verification/requant_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module requant_tb_clock (
    output logic clk
);

    // free running clock, 100 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verification/requant_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module requant_tb
    import quant_cfg_pkg::*;
    import quant_types_pkg::*;
();

    //////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////

    logic                 clk;
    // high from time 0 until the reset process releases it
    logic                 e_tail_reset = 1'b1;
    logic [row_width-1:0] add_bias_row;
    quant_mode_e          mode;
    scale_set_t           scale_set;
    logic                 quantify_en;
    logic                 quantify_reset;
    quant_row_t           quantified_row;

    // fixed seed for all random stimulus
    integer seed = 32'h33b2;
    int     check_count = 0;
    int     mismatch_count = 0;
    int     timeout_count = 0;

    // model state with one copy per DUT register stage
    logic [row_width-1:0] prod_row = '0;
    quant_mode_e          prod_mode = mode_8x8;
    scale_set_t           prod_scale = '0;
    scale_set_t           scale_model = '0;
    quant_row_t           exp_row = '0;

    requant_tb_clock u_clock (
        .clk (clk)
    );

    requant_top DUT (
        .clk            (clk),
        .e_tail_reset   (e_tail_reset),
        .add_bias_row   (add_bias_row),
        .mode           (mode),
        .scale_set      (scale_set),
        .quantify_en    (quantify_en),
        .quantify_reset (quantify_reset),
        .quantified_row (quantified_row)
    );

    // reset for 16 rising edges
    initial begin
        repeat (16) @(posedge clk);
        e_tail_reset <= 1'b0;
    end

    //////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////

    // expected output row for one row, its mode and its aligned scale set
    function automatic quant_row_t predict_row(input logic [row_width-1:0] row,
                                               input quant_mode_e m, input scale_set_t s);
        quant_row_t             q;
        logic [mult_p_width-1:0] a;
        logic [mult_p_width-1:0] prod;
        logic [mult_p_width-1:0] shifted;
        int                      ch;
        q = '0;
        for (int i = 0; i < lane_num; i++) begin
            ch = i / lanes_per_chan;
            if (m == mode_8x8 && ch == 1) begin
                // idle upper half in mode 8x8
                q.pix[i] = '0;
            end else begin
                if (m == mode_8x8) begin
                    a = mult_p_width'(row[i*pix88_width +: pix88_width]);
                end else begin
                    a = mult_p_width'(row[i*pix18_width +: pix18_width]);
                end
                prod = a * mult_p_width'(s.tail[ch]);
                // 1x8 keeps only the low 32 product bits
                if (m == mode_1x8) begin
                    prod[mult_p_width-1:prod18_width] = '0;
                end
                shifted = prod >> s.rank[ch];
                q.pix[i] = (shifted < mult_p_width'(256)) ? shifted[qpix_width-1:0] : '0;
            end
        end
        return q;
    endfunction

    //////////////////////////////////////////////////////////////
    // random stimulus
    //////////////////////////////////////////////////////////////

    function automatic logic [row_width-1:0] random_row();
        logic [row_width-1:0] r;
        for (int w = 0; w < row_width / 32; w++) begin
            r[w*32 +: 32] = $random(seed);
        end
        return r;
    endfunction

    // tails and ranks always differ between the two channels
    function automatic scale_set_t random_scale();
        scale_set_t s;
        for (int c = 0; c < chan_num; c++) begin
            s.tail[c] = tail_width'($random(seed));
            // ranks 16..39 reach the fit window of both modes
            s.rank[c] = rank_width'(16 + ($unsigned($random(seed)) % 24));
        end
        if (s.tail[1] == s.tail[0]) begin
            s.tail[1] = s.tail[0] + tail_width'(1);
        end
        if (s.rank[1] == s.rank[0]) begin
            s.rank[1] = s.rank[0] + rank_width'(1);
        end
        return s;
    endfunction

    //////////////////////////////////////////////////////////////
    // checks and cycle driver
    //////////////////////////////////////////////////////////////

    task automatic check_quant_row(input quant_row_t expected, input quant_row_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: quantified_row expected %h, got %h",
                     $time, expected, actual);
        end
    endtask

    // entered right after a rising edge and returns after the next one
    task automatic run_cycle(input logic [row_width-1:0] row, input quant_mode_e m,
                             input scale_set_t s, input logic en, input logic clr);
        add_bias_row   <= row;
        mode           <= m;
        scale_set      <= s;
        quantify_en    <= en;
        quantify_reset <= clr;
        // output is stable mid cycle
        @(negedge clk);
        check_quant_row(exp_row, quantified_row);
        @(posedge clk);
        // output register sees the product stage of the cycle before
        if (clr) begin
            exp_row = '0;
        end else if (en) begin
            exp_row = predict_row(prod_row, prod_mode, prod_scale);
        end
        prod_row    = row;
        prod_mode   = m;
        prod_scale  = scale_model;
        scale_model = s;
    endtask

    // mode_kind 0 is 8x8, 1 is 1x8, 2 random per cycle
    // ctrl_kind 0 keeps en low, 1 keeps en high, 2 random en and clear
    task automatic drive_random(input int count, input int mode_kind, input int ctrl_kind);
        quant_mode_e m;
        logic        en;
        logic        clr;
        for (int n = 0; n < count; n++) begin
            if (mode_kind == 2) begin
                m = (($random(seed) & 1) != 0) ? mode_1x8 : mode_8x8;
            end else begin
                m = (mode_kind == 1) ? mode_1x8 : mode_8x8;
            end
            en = (ctrl_kind == 1) || (ctrl_kind == 2 && ($random(seed) & 3) != 0);
            clr = (ctrl_kind == 2) && (($random(seed) & 15) == 0);
            run_cycle(random_row(), m, random_scale(), en, clr);
        end
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        while (e_tail_reset !== 1'b0 && cycles < 64) begin
            @(posedge clk);
            cycles++;
        end
        released = (e_tail_reset === 1'b0);
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////

    initial begin
        bit released;
        add_bias_row   = '0;
        mode           = mode_8x8;
        scale_set      = '0;
        quantify_en    = 1'b0;
        quantify_reset = 1'b0;
        wait_reset_release(released);
        if (!released) begin
            timeout_count++;
            $display("timeout: e_tail_reset was never released");
        end else begin
            // output stays zero while en is low
            drive_random(6, 2, 0);
            // single channel rows
            drive_random(40, 0, 1);
            // two channel rows, distinct controls per channel
            drive_random(40, 1, 1);
            // mode and scale set change every cycle
            drive_random(200, 2, 1);
            // hold with en low, then clear while en is high
            drive_random(6, 2, 0);
            run_cycle(random_row(), mode_1x8, random_scale(), 1'b1, 1'b1);
            drive_random(10, 2, 1);
            // random en and clear pulses
            drive_random(120, 2, 2);
            @(negedge clk);
            check_quant_row(exp_row, quantified_row);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* compile.f */
hw/quant_cfg_pkg.sv
hw/quant_types_pkg.sv
hw/scale_operand_stage.sv
hw/scale_mult_array.sv
hw/quant_output_stage.sv
hw/requant_top.sv
verification/requant_tb_clock.sv
verification/requant_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the requant testbench with Verilator and run it
# pass is decided by the pass message in the simulation output
verilator --binary --timing --timescale 1ns/100ps --top-module requant_tb \
    -f compile.f -o requant_sim \
    && out="$(./obj_dir/requant_sim)" \
    && printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
